// File: hdl/apu_reg_pkg.sv
`default_nettype none

package apu_reg_pkg;

	// One register byte, read as control or as sweep fields
	typedef union packed {
		struct packed {
			logic [1:0] duty;
			logic       halt;
			logic       const_vol;
			logic [3:0] vol;
		} ctrl;
		struct packed {
			logic       en;
			logic [2:0] period;
			logic       negate;
			logic [2:0] shift;
		} sweep;
	} reg_byte_u;

	localparam int REG_IDX_W = 2;

	// Status read and channel enable write
	localparam logic [4:0] STATUS_ADDR = 5'd21;

	// Voice select within addresses 0 to 7
	localparam int CH_ADDR_BIT = 2;

	// Length counter load values, indexed by register 3 bits 7:3
	localparam logic [7:0] LENGTH_TABLE [32] = '{
		8'd10,  8'd254, 8'd20, 8'd2,  8'd40, 8'd4,  8'd80, 8'd6,
		8'd160, 8'd8,   8'd60, 8'd10, 8'd14, 8'd12, 8'd26, 8'd14,
		8'd12,  8'd16,  8'd24, 8'd18, 8'd48, 8'd20, 8'd96, 8'd22,
		8'd192, 8'd24,  8'd72, 8'd26, 8'd16, 8'd28, 8'd32, 8'd30
	};

endpackage

`default_nettype wire

// File: hdl/apu_audio_pkg.sv
`default_nettype none

package apu_audio_pkg;

	// Voice output level
	localparam int VOL_W = 4;

	// Sum of two voices
	localparam int SAMPLE_W = 5;

	// Pulse timer period
	localparam int TIMER_W = 11;

endpackage

`default_nettype wire

// File: hdl/apu_reg_decode.sv
`default_nettype none

module apu_reg_decode (
	input  logic                              sys_clk,
	input  logic                              sys_rst_n,
	input  logic                              bus_sel,
	input  logic                              bus_we,
	input  logic [4:0]                        bus_addr,
	input  logic [7:0]                        bus_wdata,
	input  logic [1:0]                        act,
	output logic [1:0]                        ch_we,
	output logic [apu_reg_pkg::REG_IDX_W-1:0] reg_idx,
	output logic [7:0]                        wdata,
	output logic [1:0]                        ch_en,
	output logic [7:0]                        bus_rdata
);
	import apu_reg_pkg::*;

	logic wr;
	logic voice_hit;
	logic status_hit;

	assign wr = bus_sel && bus_we;
	// Voice registers live at 0 to 7 only
	assign voice_hit = bus_addr[4:CH_ADDR_BIT+1] == '0;
	assign status_hit = bus_addr == STATUS_ADDR;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			ch_we <= 2'b00;
			ch_en <= 2'b00;
			bus_rdata <= 8'h00;
		end else begin
			ch_we <= 2'b00;
			if (wr && voice_hit)
				ch_we[bus_addr[CH_ADDR_BIT]] <= 1'b1;
			if (wr && status_hit)
				ch_en <= bus_wdata[1:0];
			// Status byte holds until the next read
			if (bus_sel && !bus_we)
				bus_rdata <= {6'b000000, act};
		end
	end

	always_ff @(posedge sys_clk) begin
		if (wr && voice_hit) begin
			reg_idx <= bus_addr[REG_IDX_W-1:0];
			wdata <= bus_wdata;
		end
	end

endmodule

`default_nettype wire

// File: hdl/apu_frame_seq.sv
`default_nettype none

module apu_frame_seq #(
	parameter int TICK_DIV = 2,
	parameter int QFRAME_DIV = 8
) (
	input  logic sys_clk,
	input  logic sys_rst_n,
	output logic tick,
	output logic qframe,
	output logic hframe
);

	localparam int TICK_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
	localparam int QF_W = (QFRAME_DIV > 1) ? $clog2(QFRAME_DIV) : 1;

	logic [TICK_W-1:0] tick_cnt;
	logic [QF_W-1:0]   qf_cnt;
	logic              half_sel;
	logic              tick_wrap;
	logic              qf_wrap;

	assign tick_wrap = tick_cnt == TICK_W'(TICK_DIV - 1);
	assign qf_wrap = tick_wrap && (qf_cnt == QF_W'(QFRAME_DIV - 1));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			tick_cnt <= '0;
			qf_cnt <= '0;
			half_sel <= 1'b0;
			tick <= 1'b0;
			qframe <= 1'b0;
			hframe <= 1'b0;
		end else begin
			tick_cnt <= tick_wrap ? '0 : tick_cnt + 1'b1;
			// Quarter-frame divider only advances on channel ticks
			if (tick_wrap)
				qf_cnt <= qf_wrap ? '0 : qf_cnt + 1'b1;
			if (qf_wrap)
				half_sel <= ~half_sel;
			tick <= tick_wrap;
			qframe <= qf_wrap;
			hframe <= qf_wrap && half_sel;
		end
	end

endmodule

`default_nettype wire

// File: hdl/apu_pulse.sv
`default_nettype none

module apu_pulse #(
	parameter logic DEFECT = 1'b0
) (
	input  logic                              sys_clk,
	input  logic                              sys_rst_n,
	input  logic                              we,
	input  logic [apu_reg_pkg::REG_IDX_W-1:0] reg_idx,
	input  logic [7:0]                        wdata,
	input  logic                              en,
	input  logic                              tick,
	input  logic                              qframe,
	input  logic                              hframe,
	output logic [apu_audio_pkg::VOL_W-1:0]   vol,
	output logic                              act
);
	import apu_reg_pkg::*;
	import apu_audio_pkg::*;

	reg_byte_u          ctrl_r;
	reg_byte_u          sweep_r;
	logic [TIMER_W-1:0] period;
	logic [TIMER_W-1:0] timer_cnt;
	logic [2:0]         seq_step;
	logic               env_start;
	logic [VOL_W-1:0]   env_div;
	logic [VOL_W-1:0]   env_cnt;
	logic               swp_reload;
	logic [2:0]         swp_div;
	logic [7:0]         len_cnt;
	logic               wr0;
	logic               wr1;
	logic               wr2;
	logic               wr3;
	logic [TIMER_W-1:0] swp_delta;
	logic [TIMER_W-1:0] swp_target;
	logic               swp_carry;
	logic               swp_ok;
	logic               swp_mute;
	logic               swp_apply;
	logic               duty_gate;
	logic               gate;

	assign wr0 = we && en && reg_idx == 2'd0;
	assign wr1 = we && en && reg_idx == 2'd1;
	assign wr2 = we && en && reg_idx == 2'd2;
	assign wr3 = we && en && reg_idx == 2'd3;

	// Sweep target, one's complement negate when DEFECT is set
	assign swp_delta = (period >> sweep_r.sweep.shift) ^ {TIMER_W{sweep_r.sweep.negate}};
	assign {swp_carry, swp_target} = {1'b0, period} + {1'b0, swp_delta} +
		{{TIMER_W{1'b0}}, ~DEFECT & sweep_r.sweep.negate};
	assign swp_ok = sweep_r.sweep.negate ? swp_carry : ~swp_carry;
	assign swp_mute = ~sweep_r.sweep.negate & swp_carry;
	assign swp_apply = hframe && swp_div == 3'd0 && sweep_r.sweep.en &&
		sweep_r.sweep.shift != 3'd0 && swp_ok;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			ctrl_r <= '0;
			sweep_r <= '0;
			period <= '0;
		end else if (!en) begin
			ctrl_r <= '0;
			sweep_r <= '0;
			period <= '0;
		end else begin
			if (wr0)
				ctrl_r <= wdata;
			if (wr1)
				sweep_r <= wdata;
			if (wr2)
				period[7:0] <= wdata;
			else if (wr3)
				period[TIMER_W-1:8] <= wdata[2:0];
			else if (swp_apply)
				period <= swp_target;
		end
	end

	// Timer steps the duty sequencer downwards
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			timer_cnt <= '0;
			seq_step <= 3'd0;
		end else if (!en) begin
			timer_cnt <= '0;
			seq_step <= 3'd0;
		end else if (wr3) begin
			timer_cnt <= {wdata[2:0], period[7:0]};
			seq_step <= 3'd0;
		end else if (tick) begin
			if (timer_cnt == '0) begin
				timer_cnt <= period;
				seq_step <= seq_step - 3'd1;
			end else begin
				timer_cnt <= timer_cnt - 1'b1;
			end
		end
	end

	always_comb begin
		case (ctrl_r.ctrl.duty)
			2'd0: duty_gate = seq_step == 3'b111;
			2'd1: duty_gate = seq_step[2:1] == 2'b11;
			2'd2: duty_gate = seq_step[2];
			default: duty_gate = seq_step[2:1] != 2'b11;
		endcase
	end

	// Envelope, halt doubles as loop
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			env_start <= 1'b0;
			env_div <= '0;
			env_cnt <= '0;
		end else if (!en) begin
			env_start <= 1'b0;
			env_div <= '0;
			env_cnt <= '0;
		end else begin
			if (qframe) begin
				if (env_start) begin
					env_div <= ctrl_r.ctrl.vol;
					env_cnt <= '1;
				end else if (env_div == '0) begin
					env_div <= ctrl_r.ctrl.vol;
					if (env_cnt != '0 || ctrl_r.ctrl.halt)
						env_cnt <= env_cnt - 1'b1;
				end else begin
					env_div <= env_div - 1'b1;
				end
			end
			if (wr3)
				env_start <= 1'b1;
			else if (qframe)
				env_start <= 1'b0;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			swp_reload <= 1'b0;
			swp_div <= 3'd0;
		end else if (!en) begin
			swp_reload <= 1'b0;
			swp_div <= 3'd0;
		end else begin
			if (hframe) begin
				if (swp_div == 3'd0 || swp_reload)
					swp_div <= sweep_r.sweep.period;
				else
					swp_div <= swp_div - 3'd1;
			end
			if (wr1)
				swp_reload <= 1'b1;
			else if (hframe)
				swp_reload <= 1'b0;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			len_cnt <= 8'd0;
		else if (!en)
			len_cnt <= 8'd0;
		else if (wr3)
			len_cnt <= LENGTH_TABLE[wdata[7:3]];
		else if (hframe && !ctrl_r.ctrl.halt && len_cnt != 8'd0)
			len_cnt <= len_cnt - 8'd1;
	end

	assign act = len_cnt != 8'd0;

	// Periods below 8 are ultrasonic and muted
	assign gate = en && act && period[TIMER_W-1:3] != '0 && duty_gate && !swp_mute;
	assign vol = gate ? (ctrl_r.ctrl.const_vol ? ctrl_r.ctrl.vol : env_cnt) : '0;

endmodule

`default_nettype wire

// File: hdl/apu_mixer.sv
`default_nettype none

module apu_mixer #(
	parameter int SAMPLE_DIV = 16,
	parameter int CREDITS = 4
) (
	input  logic                               sys_clk,
	input  logic                               sys_rst_n,
	input  logic [apu_audio_pkg::VOL_W-1:0]    vol0,
	input  logic [apu_audio_pkg::VOL_W-1:0]    vol1,
	input  logic                               credit_return,
	output logic [apu_audio_pkg::SAMPLE_W-1:0] sample,
	output logic                               sample_valid
);
	import apu_audio_pkg::*;

	localparam int SLOT_W = (SAMPLE_DIV > 1) ? $clog2(SAMPLE_DIV) : 1;
	localparam int CRED_W = $clog2(CREDITS + 1);

	logic [SLOT_W-1:0] slot_cnt;
	logic [CRED_W-1:0] credits;
	logic              slot;
	logic              send;
	logic              ret_ok;

	assign slot = slot_cnt == SLOT_W'(SAMPLE_DIV - 1);
	assign send = slot && credits != '0;
	// A return at full count only counts against a send in that cycle
	assign ret_ok = credit_return && (credits != CRED_W'(CREDITS) || send);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			slot_cnt <= '0;
			credits <= CRED_W'(CREDITS);
			sample_valid <= 1'b0;
			sample <= '0;
		end else begin
			slot_cnt <= slot ? '0 : slot_cnt + 1'b1;
			if (send && !ret_ok)
				credits <= credits - 1'b1;
			else if (!send && ret_ok)
				credits <= credits + 1'b1;
			sample_valid <= send;
			// No credit means the slot is dropped
			if (send)
				sample <= SAMPLE_W'(vol0) + SAMPLE_W'(vol1);
		end
	end

endmodule

`default_nettype wire

// File: hdl/apu_top.sv
`default_nettype none

module apu_top #(
	parameter int TICK_DIV = 2,
	parameter int QFRAME_DIV = 8,
	parameter int SAMPLE_DIV = 16,
	parameter int CREDITS = 4
) (
	input  logic                               sys_clk,
	input  logic                               sys_rst_n,
	input  logic                               bus_sel,
	input  logic                               bus_we,
	input  logic [4:0]                         bus_addr,
	input  logic [7:0]                         bus_wdata,
	output logic [7:0]                         bus_rdata,
	output logic [apu_audio_pkg::SAMPLE_W-1:0] sample,
	output logic                               sample_valid,
	input  logic                               credit_return
);
	import apu_reg_pkg::*;
	import apu_audio_pkg::*;

	logic [1:0]           ch_we;
	logic [REG_IDX_W-1:0] reg_idx;
	logic [7:0]           wdata;
	logic [1:0]           ch_en;
	logic [1:0]           act;
	logic                 tick;
	logic                 qframe;
	logic                 hframe;
	logic [VOL_W-1:0]     vol0;
	logic [VOL_W-1:0]     vol1;

	apu_reg_decode decode_i (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.bus_sel   (bus_sel),
		.bus_we    (bus_we),
		.bus_addr  (bus_addr),
		.bus_wdata (bus_wdata),
		.act       (act),
		.ch_we     (ch_we),
		.reg_idx   (reg_idx),
		.wdata     (wdata),
		.ch_en     (ch_en),
		.bus_rdata (bus_rdata)
	);

	apu_frame_seq #(
		.TICK_DIV   (TICK_DIV),
		.QFRAME_DIV (QFRAME_DIV)
	) frame_i (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tick      (tick),
		.qframe    (qframe),
		.hframe    (hframe)
	);

	// Voice 0 keeps the one's complement sweep
	apu_pulse #(
		.DEFECT (1'b1)
	) pulse0_i (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.we        (ch_we[0]),
		.reg_idx   (reg_idx),
		.wdata     (wdata),
		.en        (ch_en[0]),
		.tick      (tick),
		.qframe    (qframe),
		.hframe    (hframe),
		.vol       (vol0),
		.act       (act[0])
	);

	apu_pulse #(
		.DEFECT (1'b0)
	) pulse1_i (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.we        (ch_we[1]),
		.reg_idx   (reg_idx),
		.wdata     (wdata),
		.en        (ch_en[1]),
		.tick      (tick),
		.qframe    (qframe),
		.hframe    (hframe),
		.vol       (vol1),
		.act       (act[1])
	);

	apu_mixer #(
		.SAMPLE_DIV (SAMPLE_DIV),
		.CREDITS    (CREDITS)
	) mixer_i (
		.sys_clk       (sys_clk),
		.sys_rst_n     (sys_rst_n),
		.vol0          (vol0),
		.vol1          (vol1),
		.credit_return (credit_return),
		.sample        (sample),
		.sample_valid  (sample_valid)
	);

endmodule

`default_nettype wire

// File: verif/apu_tb.sv
`default_nettype none

module apu_tb;
	import apu_reg_pkg::*;

	localparam int TICK_DIV = 2;
	localparam int QFRAME_DIV = 8;
	localparam int SAMPLE_DIV = 16;
	localparam int CREDITS = 4;
	localparam int MAX_E = 12;

	logic       sys_clk;
	logic       sys_rst_n;
	logic       bus_sel;
	logic       bus_we;
	logic [4:0] bus_addr;
	logic [7:0] bus_wdata;
	logic [7:0] bus_rdata;
	logic [4:0] sample;
	logic       sample_valid;
	logic       credit_return = 1'b0;

	// Stimulus table, one row per entry
	int          e_nwr [MAX_E];
	logic [4:0]  w_addr [MAX_E][8];
	logic [7:0]  w_data [MAX_E][8];
	int          e_dur [MAX_E];
	int          e_st_first [MAX_E];
	int          e_st_last [MAX_E];
	logic [31:0] e_allowed [MAX_E];
	logic [31:0] e_need [MAX_E];
	int          e_min [MAX_E];
	bit          e_hold [MAX_E];
	int          n_entries = 0;

	int          errors = 0;
	int          cycle = 0;
	int          limit = 0;
	int          seed;
	bit          withhold = 1'b0;
	bit          hold_q = 1'b0;
	bit          observing = 1'b0;
	logic [31:0] allowed = '0;
	logic [31:0] seen = '0;
	int          n_smp = 0;
	int          held = 0;
	int          last_held = 0;
	int          owed = 0;
	int          due_q [$];

	apu_top #(
		.TICK_DIV   (TICK_DIV),
		.QFRAME_DIV (QFRAME_DIV),
		.SAMPLE_DIV (SAMPLE_DIV),
		.CREDITS    (CREDITS)
	) dut_i (
		.sys_clk       (sys_clk),
		.sys_rst_n     (sys_rst_n),
		.bus_sel       (bus_sel),
		.bus_we        (bus_we),
		.bus_addr      (bus_addr),
		.bus_wdata     (bus_wdata),
		.bus_rdata     (bus_rdata),
		.sample        (sample),
		.sample_valid  (sample_valid),
		.credit_return (credit_return)
	);

	initial sys_clk = 1'b0;
	always #4 sys_clk = ~sys_clk;

	always @(posedge sys_clk) cycle <= cycle + 1;

	function automatic logic [31:0] one_hot(input int v);
		return 32'd1 << v;
	endfunction

	// Status must fall within this many cycles of a length load
	function automatic int length_bound(input int k);
		return (int'(LENGTH_TABLE[k]) + 1) * 2 * QFRAME_DIV * TICK_DIV;
	endfunction

	task automatic check(input bit ok, input string msg);
		assert (ok) else begin
			$display("FAILED @%0t: %s", $time, msg);
			errors++;
		end
	endtask

	task automatic next_cycle;
		@(posedge sys_clk);
		#1;
	endtask

	task automatic new_entry(input int dur, input int st_first, input int st_last,
		input logic [31:0] ok_vals, input logic [31:0] need_vals, input int min_smp,
		input bit hold);
		e_nwr[n_entries] = 0;
		e_dur[n_entries] = dur;
		e_st_first[n_entries] = st_first;
		e_st_last[n_entries] = st_last;
		e_allowed[n_entries] = ok_vals;
		e_need[n_entries] = need_vals;
		e_min[n_entries] = min_smp;
		e_hold[n_entries] = hold;
		n_entries++;
	endtask

	task automatic add_write(input logic [4:0] addr, input logic [7:0] data);
		w_addr[n_entries-1][e_nwr[n_entries-1]] = addr;
		w_data[n_entries-1][e_nwr[n_entries-1]] = data;
		e_nwr[n_entries-1]++;
	endtask

	task automatic bus_write(input logic [4:0] addr, input logic [7:0] data);
		bus_sel = 1'b1;
		bus_we = 1'b1;
		bus_addr = addr;
		bus_wdata = data;
		next_cycle();
		bus_sel = 1'b0;
		bus_we = 1'b0;
	endtask

	task automatic read_status(output logic [7:0] val);
		bus_sel = 1'b1;
		bus_we = 1'b0;
		bus_addr = STATUS_ADDR;
		next_cycle();
		bus_sel = 1'b0;
		val = bus_rdata;
	endtask

	task automatic build_table;
		new_entry(128, 0, 0, one_hot(0), one_hot(0), 1, 1'b0);
		// Voice 0, duty 2, halt, constant volume 11, period 40
		new_entry(1400, 1, 1, one_hot(0) | one_hot(11), one_hot(0) | one_hot(11), 1, 1'b0);
		add_write(STATUS_ADDR, 8'h01);
		add_write(5'd0, 8'hbb);
		add_write(5'd1, 8'h00);
		add_write(5'd2, 8'h28);
		add_write(5'd3, 8'h08);
		// Period 5 is muted
		new_entry(400, 1, -1, one_hot(0), one_hot(0), 1, 1'b0);
		add_write(5'd2, 8'h05);
		new_entry(1400, 3, 3, one_hot(0) | one_hot(5) | one_hot(9) | one_hot(14),
			one_hot(14), 1, 1'b0);
		add_write(STATUS_ADDR, 8'h03);
		add_write(5'd0, 8'hb5);
		add_write(5'd2, 8'h28);
		add_write(5'd3, 8'h08);
		add_write(5'd4, 8'hb9);
		add_write(5'd5, 8'h00);
		add_write(5'd6, 8'h28);
		add_write(5'd7, 8'h08);
		// Length index 3, the 6 covers settle and both reads after the load
		new_entry(length_bound(3) - 6, 1, 0, one_hot(0) | one_hot(7), '0, 0, 1'b0);
		add_write(STATUS_ADDR, 8'h01);
		add_write(5'd0, 8'h97);
		add_write(5'd3, 8'h18);
		new_entry(length_bound(3) - 6, 1, 1, one_hot(0) | one_hot(7), '0, 0, 1'b0);
		add_write(5'd0, 8'hb7);
		add_write(5'd3, 8'h18);
		new_entry(400, 0, 0, one_hot(0), one_hot(0), 1, 1'b0);
		add_write(STATUS_ADDR, 8'h00);
		new_entry(24 * SAMPLE_DIV, -1, -1, one_hot(0), '0, 0, 1'b1);
		new_entry(16 * SAMPLE_DIV, -1, -1, one_hot(0), one_hot(0), 8, 1'b0);
	endtask

	task automatic run_entry(input int e);
		logic [7:0] st;
		withhold = e_hold[e];
		held = 0;
		for (int w = 0; w < e_nwr[e]; w++)
			bus_write(w_addr[e][w], w_data[e][w]);
		// Writes reach the voice two cycles later
		repeat (4) next_cycle();
		if (e_st_first[e] >= 0) begin
			read_status(st);
			check(st == 8'(e_st_first[e]), $sformatf("entry %0d status %h after writes, expected %h",
				e, st, 8'(e_st_first[e])));
		end
		allowed = e_allowed[e];
		seen = '0;
		n_smp = 0;
		observing = 1'b1;
		repeat (e_dur[e]) next_cycle();
		observing = 1'b0;
		check((seen & e_need[e]) == e_need[e], $sformatf("entry %0d samples seen %h, need %h",
			e, seen, e_need[e]));
		check(n_smp >= e_min[e], $sformatf("entry %0d got %0d samples, expected at least %0d",
			e, n_smp, e_min[e]));
		if (e_hold[e]) begin
			check(held == CREDITS, $sformatf("entry %0d got %0d samples without credit return",
				e, held));
			check(cycle - last_held >= 10 * SAMPLE_DIV,
				$sformatf("entry %0d sample %0d cycles before end", e, cycle - last_held));
		end
		if (e_st_last[e] >= 0) begin
			read_status(st);
			check(st == 8'(e_st_last[e]), $sformatf("entry %0d status %h at end, expected %h",
				e, st, 8'(e_st_last[e])));
		end
	endtask

	// Sample monitor, mid-cycle so outputs are settled
	always @(negedge sys_clk) begin
		hold_q = withhold;
		if (sys_rst_n && sample_valid) begin
			if (observing) begin
				assert (allowed[sample]) else begin
					$display("FAILED @%0t: sample %0d not expected", $time, sample);
					errors++;
				end
				seen[sample] = 1'b1;
				n_smp++;
			end
			if (hold_q) begin
				held++;
				last_held = cycle;
				owed++;
			end else begin
				due_q.push_back(cycle + int'($urandom_range(3, 0)) * SAMPLE_DIV);
			end
		end
	end

	// Credit sink, one return per cycle at most
	always @(posedge sys_clk) begin : credit_sink
		int pick;
		#1;
		pick = -1;
		for (int i = 0; i < due_q.size(); i++)
			if (pick < 0 && due_q[i] <= cycle)
				pick = i;
		credit_return = 1'b0;
		if (pick >= 0) begin
			due_q.delete(pick);
			credit_return = 1'b1;
		end else if (!hold_q && owed > 0) begin
			owed--;
			credit_return = 1'b1;
		end
	end

	initial begin : watchdog
		wait (limit > 0);
		while (cycle < limit)
			@(negedge sys_clk);
		$display("Run did not finish within %0d cycles", limit);
		$display("Test failed");
		$finish;
	end

	initial begin
		seed = $urandom(6447);
		sys_rst_n = 1'b0;
		bus_sel = 1'b0;
		bus_we = 1'b0;
		bus_addr = '0;
		bus_wdata = '0;
		build_table();
		limit = 500;
		for (int e = 0; e < n_entries; e++)
			limit += e_dur[e];
		repeat (3) @(posedge sys_clk);
		#1;
		check(!sample_valid && bus_rdata == 8'h00, "outputs not idle during reset");
		sys_rst_n = 1'b1;
		for (int i = 1; i < SAMPLE_DIV; i++) begin
			next_cycle();
			check(!sample_valid, $sformatf("sample_valid high %0d cycles after reset", i));
		end
		next_cycle();
		check(sample_valid, "no sample at the first slot");
		for (int e = 0; e < n_entries; e++)
			run_entry(e);
		$display("Finished %0d entries with %0d errors", n_entries, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
hdl/apu_reg_pkg.sv
hdl/apu_audio_pkg.sv
hdl/apu_reg_decode.sv
hdl/apu_frame_seq.sv
hdl/apu_pulse.sv
hdl/apu_mixer.sv
hdl/apu_top.sv
verif/apu_tb.sv
